/* filelist.f */
+incdir+logic
logic/lsu_pkg.sv
logic/sb_forward_tree.sv
logic/store_buffer.sv
logic/dcache_write_ram.sv
logic/load_unit.sv
logic/lsu_store_path.sv
sim/lsu_properties.sv
sim/lsu_store_path_tb.sv

/* sim/lsu_store_path_tb.sv */
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_store_path_tb;

    typedef enum logic [3:0] {
        OP_STORE, OP_STLD, OP_COMMIT, OP_FLUSH, OP_LOAD,
        OP_STALL, OP_IDLE, OP_WAIT_FREE, OP_FULL, OP_END
    } op_t;

    // multi-word rows walk addr + 4 * (k % words)
    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [3:0]  lstrb;
        logic [3:0]  tag;
        logic [4:0]  words;
        logic [7:0]  cnt;
    } step_t;

    typedef struct packed {
        lsu_pkg::store_req_t req;
        logic                done;
    } ref_store_t;

    logic                 clk;
    logic                 reset;
    logic                 flush;
    logic                 st_valid;
    lsu_pkg::store_req_t  st_req;
    logic [1:0]           commit_cnt;
    logic                 mem_stall;
    logic                 ld_valid;
    lsu_pkg::load_query_t ld_query;
    logic                 sb_full;
    logic                 ld_resp_valid;
    lsu_pkg::load_resp_t  ld_resp;

    step_t       steps [$];
    ref_store_t  sbq [$];
    logic [31:0] ref_mem [`RAM_WORDS];
    string       test_names [1:5];
    logic [31:0] lcg_state = 32'd46743;
    int          store_seq = 0;
    int          checks = 0;
    int          errors = 0;
    int          base_checks = 0;
    int          base_errors = 0;
    int          cycles = 0;
    int          limit = 0;

    lsu_store_path i_lsu_store_path (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .st_valid      (st_valid),
        .st_req        (st_req),
        .commit_cnt    (commit_cnt),
        .mem_stall     (mem_stall),
        .ld_valid      (ld_valid),
        .ld_query      (ld_query),
        .sb_full       (sb_full),
        .ld_resp_valid (ld_resp_valid),
        .ld_resp       (ld_resp)
    );

    bind store_buffer lsu_properties i_lsu_properties (
        .clk            (clk),
        .reset          (reset),
        .mem_req        (mem_req),
        .mem_wr         (mem_wr),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .resp_slot_done (entries[resp_head].valid && entries[resp_head].complete),
        .st_valid       (st_valid),
        .sb_full        (sb_full)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run stopped after %0d cycles with the table unfinished", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic step_t row(input op_t op, input logic [31:0] addr,
                                  input logic [3:0] strb, input logic [3:0] lstrb,
                                  input logic [3:0] tag, input int words, input int cnt);
        step_t s;
        s.op    = op;
        s.addr  = addr;
        s.strb  = strb;
        s.lstrb = lstrb;
        s.tag   = tag;
        s.words = words[4:0];
        s.cnt   = cnt[7:0];
        return s;
    endfunction

    // tag 15 never goes to a store, so loads use it as no dependency
    function automatic lsu_pkg::store_req_t make_store(input step_t s, input int k);
        lsu_pkg::store_req_t req;
        logic [31:0]         rnd;
        int                  t;
        rnd      = lcg_next();
        req.addr = s.addr + 32'(4 * (k % s.words));
        req.strb = (s.strb != 4'h0) ? s.strb : rnd[27:24];
        if (req.strb == 4'h0) begin
            req.strb = 4'hF;
        end
        req.size = 3'd2;
        req.data = lcg_next();
        t        = store_seq % 15;
        req.tag  = t[`STORE_TAG_W-1:0];
        store_seq++;
        return req;
    endfunction

    function automatic lsu_pkg::load_query_t make_query(input step_t s, input int k);
        lsu_pkg::load_query_t q;
        q.addr = s.addr + 32'(4 * (k % s.words));
        q.strb = s.lstrb;
        q.tag  = s.tag;
        return q;
    endfunction

    function automatic int table_budget();
        int total;
        total = 16;
        foreach (steps[i]) begin
            case (steps[i].op)
                OP_STORE, OP_LOAD, OP_IDLE: total += steps[i].cnt;
                OP_COMMIT: total += (steps[i].cnt + 1) / 2;
                // a full buffer drains in about two cycles per store
                OP_WAIT_FREE: total += 2 * `SB_DEPTH + 4;
                default: total += 1;
            endcase
        end
        return total;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_not_full();
        while (sb_full) begin
            next_cycle();
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // youngest same-word store wins, an incoming store is younger than all
    task automatic predict_load(input lsu_pkg::load_query_t q, input logic has_in,
                                input lsu_pkg::store_req_t in_req,
                                output logic rep, output logic [31:0] data);
        logic                found;
        lsu_pkg::store_req_t young;
        found = 1'b0;
        rep   = 1'b0;
        young = '0;
        data  = ref_mem[q.addr[`RAM_IDX_W+1:2]];
        foreach (sbq[i]) begin
            if (sbq[i].req.tag == q.tag) begin
                rep = 1'b1;
            end
            if (sbq[i].req.addr[31:2] == q.addr[31:2]) begin
                found = 1'b1;
                young = sbq[i].req;
            end
        end
        if (has_in && in_req.addr[31:2] == q.addr[31:2]) begin
            found = 1'b1;
            young = in_req;
        end
        if (found && (young.strb & q.strb) != q.strb) begin
            rep = 1'b1;
        end
        for (int b = 0; b < 4; b++) begin
            if (found && q.strb[b]) begin
                data[8*b +: 8] = young.data[8*b +: 8];
            end
        end
    endtask

    task automatic issue_load(input lsu_pkg::load_query_t q, input logic has_in,
                              input lsu_pkg::store_req_t in_req);
        logic        rep;
        logic [31:0] data;
        predict_load(q, has_in, in_req, rep, data);
        ld_valid = 1'b1;
        ld_query = q;
        st_valid = has_in;
        st_req   = in_req;
        next_cycle();
        ld_valid = 1'b0;
        st_valid = 1'b0;
        if (has_in) begin
            sbq.push_back({in_req, 1'b0});
        end
        check_value($sformatf("ld_resp_valid @%h", q.addr), ld_resp_valid, 1);
        check_value($sformatf("replay @%h", q.addr), ld_resp.replay, rep);
        if (!rep) begin
            check_value($sformatf("load data @%h", q.addr), ld_resp.data, data);
        end
    endtask

    task automatic mark_committed(input int n);
        int left;
        left = n;
        foreach (sbq[i]) begin
            if (!sbq[i].done && left > 0) begin
                sbq[i].done = 1'b1;
                left--;
            end
        end
    endtask

    // committed stores reach memory in program order
    task automatic drain_model();
        ref_store_t s;
        while (sbq.size() > 0 && sbq[0].done) begin
            s = sbq.pop_front();
            for (int b = 0; b < 4; b++) begin
                if (s.req.strb[b]) begin
                    ref_mem[s.req.addr[`RAM_IDX_W+1:2]][8*b +: 8] = s.req.data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic run_step(input step_t s);
        lsu_pkg::store_req_t req;
        int                  left;
        case (s.op)
            OP_STORE: begin
                for (int k = 0; k < s.cnt; k++) begin
                    req = make_store(s, k);
                    wait_not_full();
                    st_valid = 1'b1;
                    st_req   = req;
                    next_cycle();
                    st_valid = 1'b0;
                    sbq.push_back({req, 1'b0});
                end
            end
            OP_STLD: begin
                req = make_store(s, 0);
                wait_not_full();
                issue_load(make_query(s, 0), 1'b1, req);
            end
            OP_COMMIT: begin
                left = s.cnt;
                while (left > 0) begin
                    commit_cnt = (left > 1) ? 2'd2 : 2'd1;
                    mark_committed(commit_cnt);
                    left -= commit_cnt;
                    next_cycle();
                end
                commit_cnt = 2'd0;
            end
            OP_FLUSH: begin
                flush = 1'b1;
                next_cycle();
                flush = 1'b0;
                while (sbq.size() > 0 && !sbq[$].done) begin
                    void'(sbq.pop_back());
                end
            end
            OP_LOAD: begin
                for (int k = 0; k < s.cnt; k++) begin
                    issue_load(make_query(s, k), 1'b0, '0);
                end
            end
            OP_STALL: begin
                mem_stall = s.cnt[0];
                next_cycle();
            end
            OP_IDLE: begin
                repeat (s.cnt) next_cycle();
                if (!mem_stall) begin
                    drain_model();
                end
            end
            OP_WAIT_FREE: wait_not_full();
            OP_FULL: check_value("sb_full", sb_full, s.cnt[0]);
            default: begin
                $display("test %0d %s: %0d checks, %0d errors", s.cnt, test_names[s.cnt],
                         checks - base_checks, errors - base_errors);
                base_checks = checks;
                base_errors = errors;
            end
        endcase
    endtask

    task automatic build_table();
        test_names[1] = "drain to memory";
        test_names[2] = "youngest-store forwarding";
        test_names[3] = "replay on conflict";
        test_names[4] = "flush";
        test_names[5] = "full and back-pressure";
        // strb 0 on a store row means a random strobe
        steps.push_back(row(OP_STORE, 32'h40, 4'h0, 4'h0, 4'd0, 8, 8));
        steps.push_back(row(OP_STORE, 32'h44, 4'h0, 4'h0, 4'd0, 2, 2));
        steps.push_back(row(OP_COMMIT, 32'h0, 4'h0, 4'h0, 4'd0, 1, 10));
        steps.push_back(row(OP_IDLE, 32'h0, 4'h0, 4'h0, 4'd0, 1, 40));
        steps.push_back(row(OP_LOAD, 32'h40, 4'h0, 4'hF, 4'd15, 8, 8));
        steps.push_back(row(OP_END, 32'h0, 4'h0, 4'h0, 4'd0, 1, 1));
        // fillers bring the tail to slot 15 so the second 0x80 store wraps
        steps.push_back(row(OP_STORE, 32'h100, 4'hF, 4'h0, 4'd0, 5, 5));
        steps.push_back(row(OP_COMMIT, 32'h0, 4'h0, 4'h0, 4'd0, 1, 5));
        steps.push_back(row(OP_IDLE, 32'h0, 4'h0, 4'h0, 4'd0, 1, 20));
        steps.push_back(row(OP_STORE, 32'h80, 4'hF, 4'h0, 4'd0, 1, 1));
        steps.push_back(row(OP_STORE, 32'h80, 4'hF, 4'h0, 4'd0, 1, 1));
        steps.push_back(row(OP_LOAD, 32'h80, 4'h0, 4'hF, 4'd15, 1, 1));
        steps.push_back(row(OP_STLD, 32'h84, 4'hF, 4'hF, 4'd15, 1, 1));
        steps.push_back(row(OP_END, 32'h0, 4'h0, 4'h0, 4'd0, 1, 2));
        // the 0x84 store above carries tag 2
        steps.push_back(row(OP_STORE, 32'h88, 4'h3, 4'h0, 4'd0, 1, 1));
        steps.push_back(row(OP_LOAD, 32'h88, 4'h0, 4'hC, 4'd15, 1, 1));
        steps.push_back(row(OP_LOAD, 32'h88, 4'h0, 4'h1, 4'd15, 1, 1));
        steps.push_back(row(OP_LOAD, 32'h90, 4'h0, 4'hF, 4'd2, 1, 1));
        steps.push_back(row(OP_LOAD, 32'h90, 4'h0, 4'hF, 4'd15, 1, 1));
        steps.push_back(row(OP_END, 32'h0, 4'h0, 4'h0, 4'd0, 1, 3));
        steps.push_back(row(OP_COMMIT, 32'h0, 4'h0, 4'h0, 4'd0, 1, 2));
        steps.push_back(row(OP_FLUSH, 32'h0, 4'h0, 4'h0, 4'd0, 1, 1));
        steps.push_back(row(OP_IDLE, 32'h0, 4'h0, 4'h0, 4'd0, 1, 20));
        steps.push_back(row(OP_LOAD, 32'h80, 4'h0, 4'hF, 4'd15, 3, 3));
        steps.push_back(row(OP_END, 32'h0, 4'h0, 4'h0, 4'd0, 1, 4));
        steps.push_back(row(OP_STALL, 32'h0, 4'h0, 4'h0, 4'd0, 1, 1));
        steps.push_back(row(OP_STORE, 32'h200, 4'h0, 4'h0, 4'd0, 4, 16));
        steps.push_back(row(OP_FULL, 32'h0, 4'h0, 4'h0, 4'd0, 1, 1));
        steps.push_back(row(OP_COMMIT, 32'h0, 4'h0, 4'h0, 4'd0, 1, 16));
        steps.push_back(row(OP_IDLE, 32'h0, 4'h0, 4'h0, 4'd0, 1, 4));
        steps.push_back(row(OP_FULL, 32'h0, 4'h0, 4'h0, 4'd0, 1, 1));
        steps.push_back(row(OP_STALL, 32'h0, 4'h0, 4'h0, 4'd0, 1, 0));
        steps.push_back(row(OP_WAIT_FREE, 32'h0, 4'h0, 4'h0, 4'd0, 1, 1));
        steps.push_back(row(OP_IDLE, 32'h0, 4'h0, 4'h0, 4'd0, 1, 40));
        steps.push_back(row(OP_LOAD, 32'h200, 4'h0, 4'hF, 4'd15, 4, 4));
        steps.push_back(row(OP_FULL, 32'h0, 4'h0, 4'h0, 4'd0, 1, 0));
        steps.push_back(row(OP_END, 32'h0, 4'h0, 4'h0, 4'd0, 1, 5));
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        flush      = 1'b0;
        st_valid   = 1'b0;
        st_req     = '0;
        commit_cnt = 2'd0;
        mem_stall  = 1'b0;
        ld_valid   = 1'b0;
        ld_query   = '0;
        for (int w = 0; w < `RAM_WORDS; w++) begin
            ref_mem[w] = 32'd0;
        end
        build_table();
        limit = 2 * table_budget();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("sb_full after reset", sb_full, 0);
        check_value("ld_resp_valid after reset", ld_resp_valid, 0);
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        check_value("bound assertion failures",
                    i_lsu_store_path.i_store_buffer.i_lsu_properties.prop_fails, 0);
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sim/lsu_properties.sv */
`timescale 1ns/100ps

module lsu_properties (
    input logic                clk,
    input logic                reset,
    input logic                mem_req,
    input lsu_pkg::mem_write_t mem_wr,
    input logic                addr_ok,
    input logic                data_ok,
    input logic                resp_slot_done,
    input logic                st_valid,
    input logic                sb_full
);

    // running count of failed properties
    int prop_fails = 0;

    // request and payload wait for acceptance
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req && !addr_ok |=> mem_req && $stable(mem_wr))
    else begin
        $error("drain request dropped or changed before addr_ok");
        prop_fails++;
    end

    // every response follows an accepted request and retires a completed store
    a_resp_after_req: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> $past(mem_req && addr_ok) && resp_slot_done)
    else begin
        $error("data_ok without an accepted request or a completed store to free");
        prop_fails++;
    end

    a_no_enq_full: assert property (@(posedge clk) disable iff (reset)
        !(st_valid && sb_full))
    else begin
        $error("store offered while the buffer is full");
        prop_fails++;
    end

endmodule

/* logic/lsu_store_path.sv */
`timescale 1ns/100ps

module lsu_store_path (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 st_valid,
    input  lsu_pkg::store_req_t  st_req,
    input  logic [1:0]           commit_cnt,
    input  logic                 mem_stall,
    input  logic                 ld_valid,
    input  lsu_pkg::load_query_t ld_query,
    output logic                 sb_full,
    output logic                 ld_resp_valid,
    output lsu_pkg::load_resp_t  ld_resp
);

    logic                 mem_req;
    lsu_pkg::mem_write_t  mem_wr;
    logic                 addr_ok;
    logic                 data_ok;
    lsu_pkg::load_query_t sb_query;
    lsu_pkg::fwd_result_t fwd;
    lsu_pkg::virt_t       rd_addr;
    logic [31:0]          rd_data;

    store_buffer i_store_buffer (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .st_valid   (st_valid),
        .st_req     (st_req),
        .commit_cnt (commit_cnt),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .ld_query   (sb_query),
        .sb_full    (sb_full),
        .mem_req    (mem_req),
        .mem_wr     (mem_wr),
        .fwd        (fwd)
    );

    dcache_write_ram i_dcache_write_ram (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_wr    (mem_wr),
        .mem_stall (mem_stall),
        .rd_addr   (rd_addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rd_data   (rd_data)
    );

    load_unit i_load_unit (
        .clk           (clk),
        .reset         (reset),
        .ld_valid      (ld_valid),
        .ld_query_in   (ld_query),
        .fwd           (fwd),
        .rd_data       (rd_data),
        .ld_query      (sb_query),
        .rd_addr       (rd_addr),
        .ld_resp_valid (ld_resp_valid),
        .ld_resp       (ld_resp)
    );

endmodule

/* logic/load_unit.sv */
`timescale 1ns/100ps

module load_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ld_valid,
    input  lsu_pkg::load_query_t ld_query_in,
    input  lsu_pkg::fwd_result_t fwd,
    input  logic [31:0]          rd_data,
    output lsu_pkg::load_query_t ld_query,
    output lsu_pkg::virt_t       rd_addr,
    output logic                 ld_resp_valid,
    output lsu_pkg::load_resp_t  ld_resp
);

    logic [31:0] merged;

    // probe buffer and cache in the same cycle
    assign ld_query = ld_query_in;
    assign rd_addr  = ld_query_in.addr;

    // forwarded lanes over the RAM word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (fwd.hit && ld_query_in.strb[b]) begin
                merged[8*b +: 8] = fwd.data[8*b +: 8];
            end else begin
                merged[8*b +: 8] = rd_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_resp_valid <= 1'b0;
        end else begin
            ld_resp_valid <= ld_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid) begin
            ld_resp.replay <= fwd.conflict;
            // replayed loads carry no data
            ld_resp.data   <= fwd.conflict ? 32'd0 : merged;
        end
    end

endmodule

/* logic/dcache_write_ram.sv */
`timescale 1ns/100ps
`include "lsu_params.svh"

module dcache_write_ram (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_req,
    input  lsu_pkg::mem_write_t mem_wr,
    input  logic                mem_stall,
    input  lsu_pkg::virt_t      rd_addr,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [31:0]         rd_data
);

    logic [31:0] mem [`RAM_WORDS];

    lsu_pkg::mem_write_t   pend_wr;
    logic                  accept;
    logic [`RAM_IDX_W-1:0] wr_idx;
    logic [`RAM_IDX_W-1:0] rd_idx;

    // one write in flight at a time
    assign addr_ok = !mem_stall && !data_ok;
    assign accept  = mem_req && addr_ok;

    assign wr_idx  = pend_wr.addr[`RAM_IDX_W+1:2];
    assign rd_idx  = rd_addr[`RAM_IDX_W+1:2];
    assign rd_data = mem[rd_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= accept;
        end
    end

    // captured write waits one cycle in the response slot
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_wr <= mem_wr;
        end
    end

    // strobed bytes land on the data_ok edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `RAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (data_ok) begin
            for (int b = 0; b < 4; b++) begin
                if (pend_wr.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= pend_wr.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* logic/store_buffer.sv */
`timescale 1ns/100ps
`include "lsu_params.svh"

module store_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 st_valid,
    input  lsu_pkg::store_req_t  st_req,
    input  logic [1:0]           commit_cnt,
    input  logic                 addr_ok,
    input  logic                 data_ok,
    input  lsu_pkg::load_query_t ld_query,
    output logic                 sb_full,
    output logic                 mem_req,
    output lsu_pkg::mem_write_t  mem_wr,
    output lsu_pkg::fwd_result_t fwd
);

    lsu_pkg::sb_entry_t entries [`SB_DEPTH];
    logic [`SB_DEPTH-1:0] marks;

    logic [`SB_IDX_W-1:0] tail;
    logic [`SB_IDX_W-1:0] head;
    logic [`SB_IDX_W-1:0] head_plus1;
    logic [`SB_IDX_W-1:0] req_head;
    logic [`SB_IDX_W-1:0] resp_head;
    logic                 tail_mark;
    logic                 head_mark;
    logic [`SB_IDX_W:0]   tail_sum;
    logic [`SB_IDX_W:0]   head_sum;
    logic [`SB_DEPTH-1:0] commit_vec;
    logic                 enq;

    logic req_valid;
    logic resp_valid;
    logic to_req;
    logic req_fire;
    logic req_allowin;
    logic resp_allowin;
    logic resp_fire;

    logic [`SB_DEPTH-1:0] addr_match;
    logic [`SB_DEPTH-1:0] tag_match;
    logic                 any_match;
    logic [`SB_IDX_W-1:0] sel_idx;
    logic                 buf_cover;
    logic                 in_match;
    logic                 in_cover;
    logic                 tag_wait;

    // entries free in order, so an occupied tail slot means no room left
    assign sb_full = entries[tail].valid;
    assign enq     = st_valid && !sb_full && !flush;

    // carry out of the pointer sums flips the wrap mark
    assign tail_sum   = {1'b0, tail} + 1'b1;
    assign head_sum   = {1'b0, head} + commit_cnt;
    assign head_plus1 = head + 1'b1;

    always_comb begin
        commit_vec = '0;
        if (commit_cnt != 2'd0) begin
            commit_vec[head] = 1'b1;
        end
        if (commit_cnt == 2'd2) begin
            commit_vec[head_plus1] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SB_DEPTH; i++) begin
                entries[i].valid    <= 1'b0;
                entries[i].complete <= 1'b0;
            end
            tail      <= '0;
            tail_mark <= 1'b0;
            head      <= '0;
            head_mark <= 1'b0;
            req_head  <= '0;
            resp_head <= '0;
        end else begin
            if (flush) begin
                // stores committed this cycle survive the flush
                for (int i = 0; i < `SB_DEPTH; i++) begin
                    if (!entries[i].complete && !commit_vec[i]) begin
                        entries[i].valid <= 1'b0;
                    end
                end
                tail      <= head_sum[`SB_IDX_W-1:0];
                tail_mark <= head_mark ^ head_sum[`SB_IDX_W];
            end else if (enq) begin
                entries[tail].req      <= st_req;
                entries[tail].valid    <= 1'b1;
                entries[tail].complete <= 1'b0;
                marks[tail]            <= tail_mark;
                tail                   <= tail_sum[`SB_IDX_W-1:0];
                tail_mark              <= tail_mark ^ tail_sum[`SB_IDX_W];
            end

            for (int i = 0; i < `SB_DEPTH; i++) begin
                if (commit_vec[i]) begin
                    entries[i].complete <= 1'b1;
                end
            end
            head      <= head_sum[`SB_IDX_W-1:0];
            head_mark <= head_mark ^ head_sum[`SB_IDX_W];

            if (req_allowin && to_req) begin
                req_head <= req_head + 1'b1;
            end

            // slot freed once the cache confirms the write
            if (resp_fire) begin
                entries[resp_head].valid    <= 1'b0;
                entries[resp_head].complete <= 1'b0;
                resp_head                   <= resp_head + 1'b1;
            end
        end
    end

    // drain pipeline: request stage then response stage
    assign to_req       = entries[req_head].valid && entries[req_head].complete;
    assign req_fire     = req_valid && addr_ok;
    assign req_allowin  = !req_valid || req_fire;
    assign resp_fire    = resp_valid && data_ok;
    assign resp_allowin = !resp_valid || data_ok;
    assign mem_req      = req_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid  <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            if (req_allowin) begin
                req_valid <= to_req;
            end
            if (resp_allowin) begin
                resp_valid <= req_fire;
            end
        end
    end

    // payload held while the request waits for addr_ok
    always_ff @(posedge clk) begin
        if (req_allowin) begin
            mem_wr.addr <= entries[req_head].req.addr;
            mem_wr.strb <= entries[req_head].req.strb;
            mem_wr.size <= entries[req_head].req.size;
            mem_wr.data <= entries[req_head].req.data;
        end
    end

    // load lookup over word addresses
    always_comb begin
        for (int i = 0; i < `SB_DEPTH; i++) begin
            addr_match[i] = entries[i].valid
                         && entries[i].req.addr[31:2] == ld_query.addr[31:2];
            tag_match[i]  = entries[i].valid && entries[i].req.tag == ld_query.tag;
        end
    end

    sb_forward_tree i_sb_forward_tree (
        .match     (addr_match),
        .mark      (marks),
        .any_match (any_match),
        .sel_idx   (sel_idx)
    );

    assign tag_wait  = |tag_match;
    assign buf_cover = (entries[sel_idx].req.strb & ld_query.strb) == ld_query.strb;
    assign in_match  = enq && st_req.addr[31:2] == ld_query.addr[31:2];
    assign in_cover  = (st_req.strb & ld_query.strb) == ld_query.strb;

    always_comb begin
        fwd = '0;
        // the store arriving this cycle is younger than anything buffered
        if (in_match) begin
            fwd.hit      = in_cover;
            fwd.conflict = !in_cover;
            fwd.data     = st_req.data;
        end else if (any_match) begin
            fwd.hit      = buf_cover;
            fwd.conflict = !buf_cover;
            fwd.data     = entries[sel_idx].req.data;
        end
        if (tag_wait) begin
            fwd.conflict = 1'b1;
        end
        if (fwd.conflict) begin
            fwd.hit  = 1'b0;
            fwd.data = '0;
        end
    end

endmodule

/* logic/sb_forward_tree.sv */
`timescale 1ns/100ps
`include "lsu_params.svh"

module sb_forward_tree (
    input  logic [`SB_DEPTH-1:0] match,
    input  logic [`SB_DEPTH-1:0] mark,
    output logic                 any_match,
    output logic [`SB_IDX_W-1:0] sel_idx
);

    localparam int NODES = 2 * `SB_DEPTH;

    // heap order: node 1 is the root, entry i sits at leaf SB_DEPTH + i
    logic                 node_match [1:NODES-1];
    logic                 node_mark  [1:NODES-1];
    logic [`SB_IDX_W-1:0] node_idx   [1:NODES-1];

    for (genvar i = 0; i < `SB_DEPTH; i++) begin : g_leaf
        localparam logic [`SB_IDX_W-1:0] LEAF_IDX = i;

        assign node_match[`SB_DEPTH + i] = match[i];
        assign node_mark[`SB_DEPTH + i]  = mark[i];
        assign node_idx[`SB_DEPTH + i]   = LEAF_IDX;
    end

    for (genvar n = 1; n < `SB_DEPTH; n++) begin : g_node
        logic lo_match;
        logic hi_match;
        logic take_lo;

        assign lo_match = node_match[2*n];
        assign hi_match = node_match[2*n+1];

        // lower half holds smaller slots
        // differing marks mean the lower slot was written after the wrap
        assign take_lo = (lo_match && hi_match) ? (node_mark[2*n] ^ node_mark[2*n+1])
                                                : lo_match;

        assign node_match[n] = lo_match || hi_match;
        assign node_mark[n]  = take_lo ? node_mark[2*n] : node_mark[2*n+1];
        assign node_idx[n]   = take_lo ? node_idx[2*n] : node_idx[2*n+1];
    end

    assign any_match = node_match[1];
    assign sel_idx   = node_idx[1];

endmodule

/* logic/lsu_pkg.sv */
`include "lsu_params.svh"

package lsu_pkg;

    // byte address of a word access
    typedef logic [31:0] virt_t;

    // one store as issued by the pipeline
    typedef struct packed {
        virt_t                   addr;
        logic [3:0]              strb;
        logic [2:0]              size;
        logic [31:0]             data;
        logic [`STORE_TAG_W-1:0] tag;
    } store_req_t;

    // buffered store with its state bits
    typedef struct packed {
        store_req_t req;
        logic       valid;
        logic       complete;
    } sb_entry_t;

    // write offered to the data cache
    typedef struct packed {
        virt_t       addr;
        logic [3:0]  strb;
        logic [2:0]  size;
        logic [31:0] data;
    } mem_write_t;

    // load probe into the store buffer
    typedef struct packed {
        virt_t                   addr;
        logic [3:0]              strb;
        logic [`STORE_TAG_W-1:0] tag;
    } load_query_t;

    // outcome of the buffer lookup
    typedef struct packed {
        logic        hit;
        logic        conflict;
        logic [31:0] data;
    } fwd_result_t;

    typedef struct packed {
        logic        replay;
        logic [31:0] data;
    } load_resp_t;

endpackage

/* logic/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// store buffer entries, kept a power of two for the select tree
`define SB_DEPTH    16
`define SB_IDX_W    4

// tag of the youngest store older than a load
`define STORE_TAG_W 4

// stand-in data cache size in words
`define RAM_WORDS   256
`define RAM_IDX_W   8

`endif
